// File: design/arith_pkg.sv
// Arithmetic unit shared definitions
`default_nettype none

package arith_pkg;

	//==========================================================================
	// Operation codes
	//==========================================================================

	// Operation select as seen on in_op
	typedef enum logic [1:0] {
		OP_MUL  = 2'b00, // Signed Booth radix-2 multiply
		OP_DIV  = 2'b01, // Unsigned restoring divide
		OP_SQRT = 2'b10, // Unsigned integer square root
		OP_NONE = 2'b11  // No operation, zero result
	} arith_op_e;

	//==========================================================================
	// Widths
	//==========================================================================

	// Default operand width (even for the root)
	localparam int DEF_WIDTH = 16;

	//==========================================================================
	// Engine FSM
	//==========================================================================

	typedef enum logic [1:0] {
		IDLE, // Waiting for an operation
		LOAD, // Operands in AQ, step counter cleared
		RUN,  // One step per clock
		DONE  // Result offered downstream
	} engine_state_e;

endpackage

`default_nettype wire

// File: design/arith_stage_if.sv
// Stage to stage operation channel
`timescale 1ns/1ps
`default_nettype none

interface arith_stage_if import arith_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH
);

	typedef logic [WIDTH-1:0] operand_t;

	logic      valid;     // Source has an item
	logic      ready;     // Destination can take it
	arith_op_e op;        // Operation of the item
	operand_t  operand_a; // Operand A, or high result word
	operand_t  operand_b; // Operand B, or low result word
	logic      div_zero;  // Divide by zero flag

	// Upstream side of a transfer
	modport src (
		output valid, op, operand_a, operand_b, div_zero,
		input  ready
	);

	// Downstream side of a transfer
	modport dst (
		input  valid, op, operand_a, operand_b, div_zero,
		output ready
	);

endinterface

`default_nettype wire

// File: design/operand_stage.sv
// Operand input register
`timescale 1ns/1ps
`default_nettype none

module operand_stage import arith_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH,
	localparam type operand_t = logic [WIDTH-1:0]
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      in_valid,
	output logic      in_ready,
	input  arith_op_e in_op,
	input  operand_t  in_a,
	input  operand_t  in_b,
	arith_stage_if.src down
);

	logic in_fire; // Input transfer this cycle

	//==========================================================================
	// Handshake
	//==========================================================================

	// Free slot, or the held item leaves this cycle
	assign in_ready = !down.valid || down.ready;
	assign in_fire  = in_valid && in_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			down.valid <= 1'b0;
		else if (in_ready)
			down.valid <= in_valid; // Refill or drain
	end

	//==========================================================================
	// Payload
	//==========================================================================

	always_ff @(posedge clk)
	begin
		if (in_fire)
		begin
			down.op        <= in_op;
			down.operand_a <= in_a;
			down.operand_b <= in_b;
			// Flag zero divisor once, engine then skips its steps
			down.div_zero  <= (in_op == OP_DIV) && (in_b == '0);
		end
	end

	// Stalled item must not change under the engine
	a_hold_stalled: assert property (
		@(posedge clk) disable iff (!arst_n)
		down.valid && !down.ready |=> down.valid && $stable(down.op) &&
			$stable(down.operand_a) && $stable(down.operand_b) && $stable(down.div_zero)
	) else $error("operand stage changed a stalled item");

endmodule

`default_nettype wire

// File: design/step_select.sv
// Next AQ step selector
`timescale 1ns/1ps
`default_nettype none

module step_select import arith_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH,
	localparam type operand_t = logic [WIDTH-1:0],
	localparam type aq_t = logic [2*WIDTH:0]
) (
	input  arith_op_e op,
	input  aq_t       aq,
	input  operand_t  m,
	output aq_t       aq_next
);

	operand_t       a;         // Upper AQ field
	operand_t       q;         // Lower AQ field
	logic           guard;     // Booth guard bit
	operand_t       q_shl2;    // Radicand after two bits leave
	logic [WIDTH:0]   a_in;    // A as the current op sees it
	logic [WIDTH:0]   m_in;    // M extended by one bit
	logic [WIDTH:0]   a_plus_m;
	logic [WIDTH+1:0] a_minus_m; // Extra bit is the borrow
	logic [WIDTH:0]   mul_sum; // Booth partial sum
	logic           trial_neg; // Trial subtract went below zero

	assign a      = aq[2*WIDTH:WIDTH+1];
	assign q      = aq[WIDTH:1];
	assign guard  = aq[0];
	assign q_shl2 = q << 2;

	// Shared adder and subtractor operands
	always_comb
	begin
		case (op)
			OP_MUL:  a_in = {a[WIDTH-1], a};                // Sign extended
			OP_DIV:  a_in = {a, q[WIDTH-1]};                // AQ shifted left by one
			default: a_in = {a[WIDTH-2:0], q[WIDTH-1:WIDTH-2]}; // Two radicand bits in
		endcase
	end

	assign m_in      = (op == OP_MUL) ? {m[WIDTH-1], m} : {1'b0, m};
	assign a_plus_m  = a_in + m_in;
	assign a_minus_m = {1'b0, a_in} - {1'b0, m_in};
	assign trial_neg = a_minus_m[WIDTH+1];

	// Booth pair Q0 and guard
	always_comb
	begin
		case ({q[0], guard})
			2'b01:   mul_sum = a_plus_m;         // End of a run of ones
			2'b10:   mul_sum = a_minus_m[WIDTH:0]; // Start of a run of ones
			default: mul_sum = a_in;
		endcase
	end

	//==========================================================================
	// Next AQ
	//==========================================================================

	always_comb
	begin
		case (op)
			OP_MUL:
				aq_next = {mul_sum, q}; // Arithmetic shift right, Q0 becomes guard
			OP_DIV:
			begin
				if (trial_neg)
					aq_next = {a_in[WIDTH-1:0], q[WIDTH-2:0], 1'b0, guard}; // Restore
				else
					aq_next = {a_minus_m[WIDTH-1:0], q[WIDTH-2:0], 1'b1, guard};
			end
			OP_SQRT:
			begin
				// New root bit goes out through the guard position
				if (trial_neg)
					aq_next = {a_in[WIDTH-1:0], q_shl2, 1'b0};
				else
					aq_next = {a_minus_m[WIDTH-1:0], q_shl2, 1'b1};
			end
			default:
				aq_next = aq; // Nothing to iterate
		endcase
	end

endmodule

`default_nettype wire

// File: design/iter_engine.sv
// Iterative arithmetic engine
`timescale 1ns/1ps
`default_nettype none

module iter_engine import arith_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH
) (
	input logic clk,
	input logic arst_n,
	arith_stage_if.dst up,
	arith_stage_if.src down
);

	localparam int HALF = WIDTH / 2; // Root width

	typedef logic [WIDTH-1:0] operand_t;
	typedef logic [2*WIDTH:0] aq_t;
	typedef logic [$clog2(WIDTH+1)-1:0] count_t;
	typedef logic [HALF-1:0] root_t;

	engine_state_e state;
	arith_op_e     op_q;      // Operation in flight
	logic          dz_q;      // Divide by zero in flight
	aq_t           aq;        // A, Q and guard
	aq_t           aq_next;
	operand_t      m_q;       // Multiplicand or divisor
	operand_t      step_m;    // M as fed to the selector
	root_t         root_q;    // Partial root
	count_t        count;     // Steps done
	count_t        last_step; // Count value of the final step
	logic          skip;      // No steps needed

	if (WIDTH % 2 != 0 || WIDTH < 4) begin : g_width_check
		$error("iter_engine needs an even WIDTH of at least 4");
	end

	assign skip      = (op_q == OP_NONE) || dz_q;
	assign last_step = (op_q == OP_SQRT) ? count_t'(HALF - 1) : count_t'(WIDTH - 1);
	assign step_m    = (op_q == OP_SQRT) ? operand_t'({root_q, 2'b01}) : m_q; // 4r + 1

	step_select #(.WIDTH(WIDTH)) step_select_i (
		.op      (op_q),
		.aq      (aq),
		.m       (step_m),
		.aq_next (aq_next)
	);

	assign up.ready   = (state == IDLE);
	assign down.valid = (state == DONE);

	//==========================================================================
	// FSM and step counter
	//==========================================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				IDLE: if (up.valid) state <= LOAD;
				LOAD:
				begin
					count <= '0;
					state <= skip ? DONE : RUN; // Zero steps for NONE and x/0
				end
				RUN:
				begin
					count <= count + count_t'(1);
					if (count == last_step)
						state <= DONE;
				end
				DONE: if (down.ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		if (up.valid && up.ready)
		begin
			op_q <= up.op;
			dz_q <= up.div_zero;
			aq   <= {operand_t'(0), up.operand_a, 1'b0}; // A cleared, Q gets operand A
			m_q  <= up.operand_b;
		end
		if (state == LOAD)
			root_q <= '0;
		if (state == RUN)
		begin
			aq     <= aq_next;
			root_q <= root_t'({root_q, aq_next[0]}); // Only meaningful for the root
		end
	end

	//==========================================================================
	// Result words
	//==========================================================================

	always_comb
	begin
		case (op_q)
			OP_MUL:
			begin
				down.operand_a = aq[2*WIDTH:WIDTH+1];
				down.operand_b = aq[WIDTH:1];
			end
			OP_DIV:
			begin
				down.operand_a = dz_q ? aq[WIDTH:1] : aq[2*WIDTH:WIDTH+1]; // Remainder
				down.operand_b = dz_q ? '1 : aq[WIDTH:1];                  // Quotient
			end
			OP_SQRT:
			begin
				down.operand_a = aq[2*WIDTH:WIDTH+1]; // Radicand minus root squared
				down.operand_b = operand_t'(root_q);
			end
			default:
			begin
				down.operand_a = '0;
				down.operand_b = '0;
			end
		endcase
	end

	assign down.op       = op_q;
	assign down.div_zero = dz_q;

	a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
		state == RUN |-> count <= WIDTH) else $error("step counter past WIDTH");
	a_ready_idle: assert property (@(posedge clk) disable iff (!arst_n)
		up.valid && up.ready |=> !up.ready)
		else $error("engine still ready after taking an item");
	a_valid_done: assert property (@(posedge clk) disable iff (!arst_n)
		down.valid && !down.ready |=> down.valid && $stable(down.operand_a) &&
			$stable(down.operand_b))
		else $error("engine result dropped or changed while stalled");

endmodule

`default_nettype wire

// File: design/result_stage.sv
// Result output register
`timescale 1ns/1ps
`default_nettype none

module result_stage import arith_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH,
	localparam type operand_t = logic [WIDTH-1:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	arith_stage_if.dst up,
	output logic     out_valid,
	input  logic     out_ready,
	output operand_t out_hi,
	output operand_t out_lo
);

	logic up_fire; // Engine hands over a result

	//==========================================================================
	// Handshake
	//==========================================================================

	// Take a result when empty or while the held one leaves
	assign up.ready = !out_valid || out_ready;
	assign up_fire  = up.valid && up.ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else if (up.ready)
			out_valid <= up.valid;
	end

	//==========================================================================
	// Result words
	//==========================================================================

	always_ff @(posedge clk)
	begin
		if (up_fire)
		begin
			out_hi <= up.operand_a; // Product high, remainder or root remainder
			out_lo <= up.operand_b; // Product low, quotient or root
		end
	end

	// A pending result stays until the sink takes it
	a_out_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_hi) && $stable(out_lo)
	) else $error("result dropped or changed while out_ready was low");

endmodule

`default_nettype wire

// File: design/arith_unit.sv
// Sequential arithmetic unit top
`timescale 1ns/1ps
`default_nettype none

module arith_unit import arith_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH,
	localparam type operand_t = logic [WIDTH-1:0]
) (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      in_valid,
	output logic      in_ready,
	input  arith_op_e in_op,
	input  operand_t  in_a,
	input  operand_t  in_b,
	output logic      out_valid,
	input  logic      out_ready,
	output operand_t  out_hi,
	output operand_t  out_lo
);

	arith_stage_if #(.WIDTH(WIDTH)) eng_in_if ();  // Operand stage to engine
	arith_stage_if #(.WIDTH(WIDTH)) eng_out_if (); // Engine to result stage

	operand_stage #(.WIDTH(WIDTH)) operand_stage_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_op    (in_op),
		.in_a     (in_a),
		.in_b     (in_b),
		.down     (eng_in_if.src)
	);

	iter_engine #(.WIDTH(WIDTH)) iter_engine_i (
		.clk    (clk),
		.arst_n (arst_n),
		.up     (eng_in_if.dst),
		.down   (eng_out_if.src)
	);

	result_stage #(.WIDTH(WIDTH)) result_stage_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.up        (eng_out_if.dst),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_hi    (out_hi),
		.out_lo    (out_lo)
	);

endmodule

`default_nettype wire

// File: bench/arith_tb_util.svh
// Random source and reference models
`ifndef ARITH_TB_UTIL_SVH
`define ARITH_TB_UTIL_SVH

//============================================================================
// Galois LFSR on x^32 + x^22 + x^2 + x + 1
//============================================================================

function automatic logic [31:0] lfsr_step(logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Feedback on lsb out
endfunction

//============================================================================
// Reference models with results packed as {hi, lo}
//============================================================================

// Signed full width product
function automatic logic [2*WIDTH-1:0] signed_product(logic [WIDTH-1:0] a,
	logic [WIDTH-1:0] b);
	logic signed [2*WIDTH-1:0] sa;
	logic signed [2*WIDTH-1:0] sb;
	sa = {{WIDTH{a[WIDTH-1]}}, a};
	sb = {{WIDTH{b[WIDTH-1]}}, b};
	return sa * sb;
endfunction

// Remainder high, quotient low
function automatic logic [2*WIDTH-1:0] quotient_and_remainder(logic [WIDTH-1:0] a,
	logic [WIDTH-1:0] b);
	if (b == '0)
		return {a, {WIDTH{1'b1}}}; // x/0 gives all ones and remainder x
	return {a % b, a / b};
endfunction

// Root remainder high, root low
function automatic logic [2*WIDTH-1:0] root_and_remainder(logic [WIDTH-1:0] a);
	longint r;
	r = 0;
	while ((r + 1) * (r + 1) <= a)
		r++; // Largest r with r*r <= a
	return {WIDTH'(a - r * r), WIDTH'(r)};
endfunction

function automatic logic [2*WIDTH-1:0] reference_result(arith_op_e op, logic [WIDTH-1:0] a,
	logic [WIDTH-1:0] b);
	case (op)
		OP_MUL:  return signed_product(a, b);
		OP_DIV:  return quotient_and_remainder(a, b);
		OP_SQRT: return root_and_remainder(a); // in_b ignored
		default: return '0;
	endcase
endfunction

`endif

// File: bench/arith_unit_tb.sv
// Arithmetic unit testbench
`timescale 1ns/1ps
`default_nettype none

module arith_unit_tb import arith_pkg::*; ();

	localparam int          WIDTH      = 16;
	localparam int          PERIOD     = 20;
	localparam int          N_DIRECT   = 18;  // Corner cases first
	localparam int          N_RANDOM   = 200;
	localparam int          N_ITEMS    = N_DIRECT + N_RANDOM;
	localparam int          MAX_CYCLES = N_ITEMS * (WIDTH + 8) * 4 + 200;
	localparam logic [31:0] SEED       = 32'h3cf8;

	typedef logic [WIDTH-1:0]   operand_t;
	typedef logic [2*WIDTH-1:0] pair_t; // {hi, lo}

	logic      clk;
	logic      arst_n;
	logic      in_valid;
	logic      in_ready;
	arith_op_e in_op;
	operand_t  in_a;
	operand_t  in_b;
	logic      out_valid;
	logic      out_ready;
	operand_t  out_hi;
	operand_t  out_lo;

	logic [31:0] lfsr;
	pair_t       exp_q[$];  // Model results in input order
	pair_t       exp_pair;  // Queue front as of the last falling edge
	logic        have_exp;
	logic        in_fire;   // Transfers due at the next rising edge
	logic        out_fire;
	int          sent;
	int          in_count;
	int          out_count;
	int          mismatches;
	int          protocol_errs;
	int          cycles = 0;

	`include "arith_tb_util.svh"

	arith_unit #(.WIDTH(WIDTH)) arith_unit_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_op     (in_op),
		.in_a      (in_a),
		.in_b      (in_b),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_hi    (out_hi),
		.out_lo    (out_lo)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, %0d results still missing", cycles, exp_q.size());
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//========================================================================
	// Stimulus helpers
	//========================================================================

	// n LFSR bits with one step each
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return bits;
	endfunction

	// Corner cases as {op, a, b}
	function automatic logic [33:0] directed_item(int idx);
		case (idx)
			0:  return {OP_MUL, 16'h8000, 16'h8000};  // Most negative squared
			1:  return {OP_MUL, 16'h8000, 16'hffff};  // Times -1
			2:  return {OP_MUL, 16'h8000, 16'h0000};
			3:  return {OP_MUL, 16'h7fff, 16'h8000};
			4:  return {OP_MUL, 16'h1234, 16'hfedc};
			5:  return {OP_DIV, 16'h0064, 16'h0007};
			6:  return {OP_DIV, 16'h0005, 16'h0009};  // Divisor above dividend
			7:  return {OP_DIV, 16'h1234, 16'h0000};  // Divide by zero
			8:  return {OP_DIV, 16'hffff, 16'h0001};
			9:  return {OP_SQRT, 16'h0000, 16'h5555};
			10: return {OP_SQRT, 16'h0001, 16'h0000};
			11: return {OP_SQRT, 16'h0090, 16'h0000}; // 12 squared
			12: return {OP_SQRT, 16'h4000, 16'h0000};
			13: return {OP_SQRT, 16'hffff, 16'hffff};
			14: return {OP_SQRT, 16'h00c8, 16'h0000};
			15: return {OP_NONE, 16'h1234, 16'h5678};
			16: return {OP_MUL, 16'hffff, 16'hffff};
			17: return {OP_DIV, 16'hffff, 16'hffff};
			default: return {OP_NONE, 32'h0};
		endcase
	endfunction

	// Pop and push for the transfers of the last rising edge
	task automatic track_transfers();
		if (out_fire)
		begin
			if (exp_q.size() != 0)
				void'(exp_q.pop_front());
			out_count++;
		end
		if (in_fire)
		begin
			exp_q.push_back(reference_result(in_op, in_a, in_b));
			in_count++;
			sent++;
		end
		have_exp = (exp_q.size() != 0);
		exp_pair = have_exp ? exp_q[0] : '0;
	endtask

	task automatic drive_inputs();
		logic [33:0] item;
		if (in_fire || !in_valid) // Offered item stays until taken
		begin
			in_valid = 1'b0;
			if (sent < N_ITEMS && take_bits(2) != 0)
			begin
				in_valid = 1'b1;
				if (sent < N_DIRECT)
					item = directed_item(sent);
				else
					item = {2'(take_bits(2)), 16'(take_bits(16)), 16'(take_bits(16))};
				in_op = arith_op_e'(item[33:32]);
				in_a  = item[31:16];
				in_b  = item[15:0];
			end
		end
		out_ready = (take_bits(2) != 0); // Stall about one cycle in four
	endtask

	//========================================================================
	// Checks
	//========================================================================

	hi_matches: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> out_hi == exp_pair[2*WIDTH-1:WIDTH])
	else
	begin
		mismatches++;
		$display("MISMATCH at %0t: out_hi expected %h actual %h", $time,
			$sampled(exp_pair[2*WIDTH-1:WIDTH]), $sampled(out_hi));
	end

	lo_matches: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> out_lo == exp_pair[WIDTH-1:0])
	else
	begin
		mismatches++;
		$display("MISMATCH at %0t: out_lo expected %h actual %h", $time,
			$sampled(exp_pair[WIDTH-1:0]), $sampled(out_lo));
	end

	no_extra_result: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> have_exp)
	else
	begin
		protocol_errs++;
		$display("Output transfer at %0t with no accepted input pending", $time);
	end

	holds_when_stalled: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_hi) && $stable(out_lo))
	else
	begin
		protocol_errs++;
		$display("Output dropped or changed during a stall at %0t", $time);
	end

	//========================================================================
	// Main sequence
	//========================================================================

	initial
	begin
		lfsr          = SEED;
		arst_n        = 1'b0;
		in_valid      = 1'b0;
		in_op         = OP_NONE;
		in_a          = '0;
		in_b          = '0;
		out_ready     = 1'b0;
		in_fire       = 1'b0;
		out_fire      = 1'b0;
		have_exp      = 1'b0;
		exp_pair      = '0;
		sent          = 0;
		in_count      = 0;
		out_count     = 0;
		mismatches    = 0;
		protocol_errs = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		#(PERIOD/4);
		idle_after_reset: assert (!out_valid && in_ready)
		else
		begin
			protocol_errs++;
			$display("After reset out_valid is high or in_ready is low");
		end
		while (out_count < N_ITEMS)
		begin
			@(negedge clk);
			track_transfers();
			drive_inputs();
			#(PERIOD/4); // Sample the handshakes once DUT outputs settle
			in_fire  = in_valid && in_ready;
			out_fire = out_valid && out_ready;
		end
		counts_agree: assert (in_count == N_ITEMS && out_count == in_count && exp_q.size() == 0)
		else
		begin
			protocol_errs++;
			$display("Got %0d results for %0d accepted inputs", out_count, in_count);
		end
		repeat (2) @(posedge clk);
		$display("Errors: %0d mismatches, %0d protocol; %0d inputs, %0d outputs",
			mismatches, protocol_errs, in_count, out_count);
		if (mismatches == 0 && protocol_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: arith_unit.f
design/arith_pkg.sv
design/arith_stage_if.sv
design/operand_stage.sv
design/step_select.sv
design/iter_engine.sv
design/result_stage.sv
design/arith_unit.sv
+incdir+bench
bench/arith_unit_tb.sv
